/* noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Mesh coordinates
`define NOC_X_W        2   // Column 0 is the host, tiles at 1 and 2
`define NOC_Y_W        1   // Single row built

// Endpoint memory
`define NOC_ADDR_W     4   // 16 words per tile
`define NOC_DATA_W     16

// Link buffering
`define NOC_FIFO_DEPTH 2

`endif

/* noc_pkg.sv */
`default_nettype none

`include "noc_consts.svh"

package noc_pkg;

  // Router port index, matches the stub_p bit order
  typedef enum logic [2:0] {
    P = 3'd0,   // Processor socket
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,   // Toward lower y
    S = 3'd4    // Toward higher y
  } dir_e;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_RDATA = 2'd2,  // Read response
    OP_WACK  = 2'd3   // Write acknowledge
  } op_e;

  typedef struct packed {
    op_e                    op;
    logic [`NOC_X_W-1:0]    dst_x;
    logic [`NOC_Y_W-1:0]    dst_y;
    logic [`NOC_X_W-1:0]    src_x;
    logic [`NOC_Y_W-1:0]    src_y;
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_DATA_W-1:0] data;
  } packet_t;

  // Response as queued inside the endpoint, before packing
  typedef struct packed {
    op_e                    op;
    logic [`NOC_X_W-1:0]    ret_x;
    logic [`NOC_Y_W-1:0]    ret_y;
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_DATA_W-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

/* link_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module link_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `NOC_FIFO_DEPTH
) (
  input  wire           clk_i,
  input  wire           reset_i,
  input  wire payload_t data_i,
  input  wire           valid_i,
  output logic          ready_o,
  output payload_t      data_o,
  output logic          valid_o,
  input  wire           ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;  // Wrap at DEPTH
  endfunction

  assign full    = (count_r == CNT_W'(DEPTH));
  assign empty   = (count_r == '0);
  assign ready_o = !full;
  assign valid_o = !empty;   // Head only, no bypass
  assign data_o  = mem_q[rd_ptr_r];
  assign push    = valid_i && !full;
  assign pop     = !empty && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop) rd_ptr_r <= next_ptr(rd_ptr_r);
      if (push && !pop) count_r <= count_r + 1'b1;
      else if (pop && !push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

/* rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire  [4:0] req_i,
  input  wire        hold_i,    // Granted packet not yet taken
  output logic [4:0] grant_o
);

  logic [2:0] last_r;     // Index of the last winner
  logic [4:0] grant_r;
  logic       locked_r;
  logic [4:0] pick;
  logic [2:0] grant_idx;

  // Search starts one past the last winner
  always_comb begin
    pick = '0;
    for (int k = 1; k <= 5; k++) begin
      if (req_i[(int'(last_r) + k) % 5] && (pick == '0)) begin
        pick[(int'(last_r) + k) % 5] = 1'b1;
      end
    end
  end

  assign grant_o = locked_r ? grant_r : pick;

  always_comb begin
    grant_idx = '0;
    for (int k = 0; k < 5; k++) begin
      if (grant_o[k]) grant_idx = 3'(k);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r   <= 3'd4;   // P wins first
      grant_r  <= '0;
      locked_r <= 1'b0;
    end else begin
      locked_r <= hold_i && (grant_o != '0);
      grant_r  <= grant_o;
      if (!hold_i && (grant_o != '0)) last_r <= grant_idx;  // Rotate on completion
    end
  end

endmodule

`default_nettype wire

/* mesh_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module mesh_router #(
  parameter logic [4:0] stub_p = 5'b0   // {S,N,E,W,P}
) (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire [`NOC_X_W-1:0]    my_x_i,
  input  wire [`NOC_Y_W-1:0]    my_y_i,

  input  wire noc_pkg::packet_t proc_link_data_i,
  input  wire                   proc_link_valid_i,
  output logic                  proc_link_ready_o,
  output noc_pkg::packet_t      proc_link_data_o,
  output logic                  proc_link_valid_o,
  input  wire                   proc_link_ready_i,

  input  wire noc_pkg::packet_t link_w_data_i,
  input  wire                   link_w_valid_i,
  output logic                  link_w_ready_o,
  output noc_pkg::packet_t      link_w_data_o,
  output logic                  link_w_valid_o,
  input  wire                   link_w_ready_i,

  input  wire noc_pkg::packet_t link_e_data_i,
  input  wire                   link_e_valid_i,
  output logic                  link_e_ready_o,
  output noc_pkg::packet_t      link_e_data_o,
  output logic                  link_e_valid_o,
  input  wire                   link_e_ready_i,

  input  wire noc_pkg::packet_t link_n_data_i,
  input  wire                   link_n_valid_i,
  output logic                  link_n_ready_o,
  output noc_pkg::packet_t      link_n_data_o,
  output logic                  link_n_valid_o,
  input  wire                   link_n_ready_i,

  input  wire noc_pkg::packet_t link_s_data_i,
  input  wire                   link_s_valid_i,
  output logic                  link_s_ready_o,
  output noc_pkg::packet_t      link_s_data_o,
  output logic                  link_s_valid_o,
  input  wire                   link_s_ready_i
);

  noc_pkg::packet_t in_data   [5];
  noc_pkg::packet_t head_data [5];
  noc_pkg::packet_t sel_data  [5];
  noc_pkg::packet_t out_data  [5];
  noc_pkg::dir_e    head_dir  [5];
  logic [4:0]       req       [5];   // Per output, one bit per input
  logic [4:0]       grant     [5];
  logic [4:0]       in_valid;
  logic [4:0]       fifo_ready;
  logic [4:0]       head_valid;
  logic [4:0]       pop;
  logic [4:0]       out_valid;
  logic [4:0]       out_ready;
  logic [4:0]       can_load;
  logic [4:0]       load;

  // X first, then Y, then local
  function automatic noc_pkg::dir_e route(input noc_pkg::packet_t p,
                                          input logic [`NOC_X_W-1:0] x,
                                          input logic [`NOC_Y_W-1:0] y);
    if (p.dst_x > x) return noc_pkg::E;
    else if (p.dst_x < x) return noc_pkg::W;
    else if (p.dst_y > y) return noc_pkg::S;
    else if (p.dst_y < y) return noc_pkg::N;
    else return noc_pkg::P;
  endfunction

  assign in_data[noc_pkg::P] = proc_link_data_i;
  assign in_data[noc_pkg::W] = link_w_data_i;
  assign in_data[noc_pkg::E] = link_e_data_i;
  assign in_data[noc_pkg::N] = link_n_data_i;
  assign in_data[noc_pkg::S] = link_s_data_i;

  assign in_valid = {link_s_valid_i, link_n_valid_i, link_e_valid_i, link_w_valid_i,
                     proc_link_valid_i} & ~stub_p;   // Stubbed inputs never valid
  assign out_ready = {link_s_ready_i, link_n_ready_i, link_e_ready_i, link_w_ready_i,
                      proc_link_ready_i};
  assign {link_s_ready_o, link_n_ready_o, link_e_ready_o, link_w_ready_o,
          proc_link_ready_o} = fifo_ready & ~stub_p;
  assign {link_s_valid_o, link_n_valid_o, link_e_valid_o, link_w_valid_o,
          proc_link_valid_o} = out_valid;

  assign proc_link_data_o = out_data[noc_pkg::P];
  assign link_w_data_o    = out_data[noc_pkg::W];
  assign link_e_data_o    = out_data[noc_pkg::E];
  assign link_n_data_o    = out_data[noc_pkg::N];
  assign link_s_data_o    = out_data[noc_pkg::S];

  for (genvar i = 0; i < 5; i++) begin : g_in
    link_fifo #(
      .payload_t(noc_pkg::packet_t),
      .DEPTH    (`NOC_FIFO_DEPTH)
    ) u_in_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .data_i (in_data[i]),
      .valid_i(in_valid[i]),
      .ready_o(fifo_ready[i]),
      .data_o (head_data[i]),
      .valid_o(head_valid[i]),
      .ready_i(pop[i])
    );
    assign head_dir[i] = route(head_data[i], my_x_i, my_y_i);
  end

  assign can_load = ~out_valid | out_ready;   // Output register free or draining

  for (genvar o = 0; o < 5; o++) begin : g_arb
    rr_arbiter u_arb (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (req[o]),
      .hold_i (!can_load[o]),
      .grant_o(grant[o])
    );
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < 5; o++) begin
      sel_data[o] = head_data[0];
      for (int i = 0; i < 5; i++) begin
        req[o][i] = head_valid[i] && (head_dir[i] == noc_pkg::dir_e'(o)) && !stub_p[o];
        if (grant[o][i]) sel_data[o] = head_data[i];
      end
      load[o] = (grant[o] != '0) && can_load[o];
      pop     = pop | (grant[o] & {5{load[o]}});  // Winning head leaves its FIFO
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < 5; o++) begin
      if (reset_i) out_valid[o] <= 1'b0;
      else if (load[o]) out_valid[o] <= 1'b1;
      else if (out_ready[o]) out_valid[o] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < 5; o++) begin
      if (load[o]) out_data[o] <= sel_data[o];
    end
  end

endmodule

`default_nettype wire

/* mem_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module mem_endpoint (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire [`NOC_X_W-1:0]    my_x_i,
  input  wire [`NOC_Y_W-1:0]    my_y_i,
  input  wire noc_pkg::packet_t req_pkt_i,
  input  wire                   req_valid_i,
  output logic                  req_ready_o,
  output noc_pkg::packet_t      resp_pkt_o,
  output logic                  resp_valid_o,
  input  wire                   resp_ready_i
);

  localparam int WORDS = 1 << `NOC_ADDR_W;

  logic [`NOC_DATA_W-1:0] mem_q [WORDS];
  logic                   is_write;
  noc_pkg::mem_resp_t     resp_in;
  noc_pkg::mem_resp_t     resp_head;

  assign is_write = (req_pkt_i.op == noc_pkg::OP_WRITE);

  // Read data is taken before this edge's write lands
  always_comb begin
    resp_in.op    = is_write ? noc_pkg::OP_WACK : noc_pkg::OP_RDATA;
    resp_in.ret_x = req_pkt_i.src_x;
    resp_in.ret_y = req_pkt_i.src_y;
    resp_in.addr  = req_pkt_i.addr;
    resp_in.data  = is_write ? req_pkt_i.data : mem_q[req_pkt_i.addr];  // WACK echoes data
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o && is_write) mem_q[req_pkt_i.addr] <= req_pkt_i.data;
  end

  // Request accepted only when the response has a slot
  link_fifo #(
    .payload_t(noc_pkg::mem_resp_t),
    .DEPTH    (`NOC_FIFO_DEPTH)
  ) u_resp_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (resp_in),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_o (resp_head),
    .valid_o(resp_valid_o),
    .ready_i(resp_ready_i)
  );

  always_comb begin
    resp_pkt_o.op    = resp_head.op;
    resp_pkt_o.dst_x = resp_head.ret_x;   // Back to the requester
    resp_pkt_o.dst_y = resp_head.ret_y;
    resp_pkt_o.src_x = my_x_i;
    resp_pkt_o.src_y = my_y_i;
    resp_pkt_o.addr  = resp_head.addr;
    resp_pkt_o.data  = resp_head.data;
  end

endmodule

`default_nettype wire

/* mem_tile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module mem_tile #(
  parameter logic [4:0] stub_p = 5'b0   // {S,N,E,W,P}
) (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire [`NOC_X_W-1:0]    my_x_i,
  input  wire [`NOC_Y_W-1:0]    my_y_i,

  input  wire noc_pkg::packet_t link_w_data_i,
  input  wire                   link_w_valid_i,
  output logic                  link_w_ready_o,
  output noc_pkg::packet_t      link_w_data_o,
  output logic                  link_w_valid_o,
  input  wire                   link_w_ready_i,

  input  wire noc_pkg::packet_t link_e_data_i,
  input  wire                   link_e_valid_i,
  output logic                  link_e_ready_o,
  output noc_pkg::packet_t      link_e_data_o,
  output logic                  link_e_valid_o,
  input  wire                   link_e_ready_i,

  input  wire noc_pkg::packet_t link_n_data_i,
  input  wire                   link_n_valid_i,
  output logic                  link_n_ready_o,
  output noc_pkg::packet_t      link_n_data_o,
  output logic                  link_n_valid_o,
  input  wire                   link_n_ready_i,

  input  wire noc_pkg::packet_t link_s_data_i,
  input  wire                   link_s_valid_i,
  output logic                  link_s_ready_o,
  output noc_pkg::packet_t      link_s_data_o,
  output logic                  link_s_valid_o,
  input  wire                   link_s_ready_i
);

  logic             reset_r;
  noc_pkg::packet_t ep_req_pkt;    // Router to endpoint
  logic             ep_req_valid;
  logic             ep_req_ready;
  noc_pkg::packet_t ep_resp_pkt;   // Endpoint to router
  logic             ep_resp_valid;
  logic             ep_resp_ready;

  // Local copy of reset, one cycle behind the top level
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  mesh_router #(
    .stub_p(stub_p)
  ) u_router (
    .clk_i            (clk_i),
    .reset_i          (reset_r),
    .my_x_i           (my_x_i),
    .my_y_i           (my_y_i),
    .proc_link_data_i (ep_resp_pkt),
    .proc_link_valid_i(ep_resp_valid),
    .proc_link_ready_o(ep_resp_ready),
    .proc_link_data_o (ep_req_pkt),
    .proc_link_valid_o(ep_req_valid),
    .proc_link_ready_i(ep_req_ready),
    .link_w_data_i, .link_w_valid_i, .link_w_ready_o,
    .link_w_data_o, .link_w_valid_o, .link_w_ready_i,
    .link_e_data_i, .link_e_valid_i, .link_e_ready_o,
    .link_e_data_o, .link_e_valid_o, .link_e_ready_i,
    .link_n_data_i, .link_n_valid_i, .link_n_ready_o,
    .link_n_data_o, .link_n_valid_o, .link_n_ready_i,
    .link_s_data_i, .link_s_valid_i, .link_s_ready_o,
    .link_s_data_o, .link_s_valid_o, .link_s_ready_i
  );

  mem_endpoint u_endpoint (
    .clk_i       (clk_i),
    .reset_i     (reset_r),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .req_pkt_i   (ep_req_pkt),
    .req_valid_i (ep_req_valid),
    .req_ready_o (ep_req_ready),
    .resp_pkt_o  (ep_resp_pkt),
    .resp_valid_o(ep_resp_valid),
    .resp_ready_i(ep_resp_ready)
  );

endmodule

`default_nettype wire

/* host_link_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module host_link_bridge (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   host_req_i,
  input  wire noc_pkg::packet_t host_pkt_i,
  output logic                  host_ack_o,
  output logic                  resp_req_o,
  output noc_pkg::packet_t      resp_pkt_o,
  input  wire                   resp_ack_i,
  output noc_pkg::packet_t      egress_pkt_o,
  output logic                  egress_valid_o,
  input  wire                   egress_ready_i,
  input  wire noc_pkg::packet_t ingress_pkt_i,
  input  wire                   ingress_valid_i,
  output logic                  ingress_ready_o
);

  typedef enum logic [1:0] {
    RSP_IDLE,
    RSP_REQ,    // resp_req_o high, waiting for ack
    RSP_WAIT    // Popped, waiting for ack to fall
  } rsp_state_e;

  logic       ack_r;
  logic       host_push;
  logic       req_fifo_ready;
  logic       rsp_valid;
  rsp_state_e rsp_state_r;

  // Request side, one push per req high phase
  assign host_push  = host_req_i && !ack_r;
  assign host_ack_o = ack_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) ack_r <= 1'b0;
    else if (host_push && req_fifo_ready) ack_r <= 1'b1;
    else if (!host_req_i) ack_r <= 1'b0;
  end

  link_fifo #(
    .payload_t(noc_pkg::packet_t),
    .DEPTH    (`NOC_FIFO_DEPTH)
  ) u_req_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (host_pkt_i),
    .valid_i(host_push),
    .ready_o(req_fifo_ready),
    .data_o (egress_pkt_o),
    .valid_o(egress_valid_o),
    .ready_i(egress_ready_i)
  );

  // Response side, head stays put until the host acks
  assign resp_req_o = (rsp_state_r == RSP_REQ);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_state_r <= RSP_IDLE;
    end else begin
      case (rsp_state_r)
        RSP_IDLE: if (rsp_valid) rsp_state_r <= RSP_REQ;
        RSP_REQ:  if (resp_ack_i) rsp_state_r <= RSP_WAIT;
        RSP_WAIT: if (!resp_ack_i) rsp_state_r <= RSP_IDLE;
        default:  rsp_state_r <= RSP_IDLE;
      endcase
    end
  end

  link_fifo #(
    .payload_t(noc_pkg::packet_t),
    .DEPTH    (`NOC_FIFO_DEPTH)
  ) u_resp_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (ingress_pkt_i),
    .valid_i(ingress_valid_i),
    .ready_o(ingress_ready_o),
    .data_o (resp_pkt_o),
    .valid_o(rsp_valid),
    .ready_i(resp_req_o && resp_ack_i)   // Pop on the ack edge
  );

endmodule

`default_nettype wire

/* mesh_pair_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module mesh_pair_top (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   host_req_i,
  input  wire noc_pkg::packet_t host_pkt_i,
  output logic                  host_ack_o,
  output logic                  resp_req_o,
  output noc_pkg::packet_t      resp_pkt_o,
  input  wire                   resp_ack_i
);

  localparam logic [`NOC_X_W-1:0] TILE1_X    = `NOC_X_W'(1);
  localparam logic [`NOC_X_W-1:0] TILE2_X    = `NOC_X_W'(2);
  localparam logic [`NOC_Y_W-1:0] ROW_Y      = '0;
  localparam logic [4:0]          STUB_NS    = 5'b11000;  // {S,N,E,W,P}
  localparam logic [4:0]          STUB_NSE   = 5'b11100;  // East edge of the row

  noc_pkg::packet_t eg_pkt;     // Bridge to tile 1 west
  logic             eg_valid;
  logic             eg_ready;
  noc_pkg::packet_t in_pkt;     // Tile 1 west to bridge
  logic             in_valid;
  logic             in_ready;
  noc_pkg::packet_t t12_pkt;    // Tile 1 east to tile 2 west
  logic             t12_valid;
  logic             t12_ready;
  noc_pkg::packet_t t21_pkt;    // Tile 2 west to tile 1 east
  logic             t21_valid;
  logic             t21_ready;

  host_link_bridge u_bridge (
    .clk_i, .reset_i,
    .host_req_i, .host_pkt_i, .host_ack_o,
    .resp_req_o, .resp_pkt_o, .resp_ack_i,
    .egress_pkt_o(eg_pkt), .egress_valid_o(eg_valid), .egress_ready_i(eg_ready),
    .ingress_pkt_i(in_pkt), .ingress_valid_i(in_valid), .ingress_ready_o(in_ready)
  );

  mem_tile #(.stub_p(STUB_NS)) u_tile1 (
    .clk_i, .reset_i,
    .my_x_i(TILE1_X), .my_y_i(ROW_Y),
    .link_w_data_i(eg_pkt), .link_w_valid_i(eg_valid), .link_w_ready_o(eg_ready),
    .link_w_data_o(in_pkt), .link_w_valid_o(in_valid), .link_w_ready_i(in_ready),
    .link_e_data_i(t21_pkt), .link_e_valid_i(t21_valid), .link_e_ready_o(t21_ready),
    .link_e_data_o(t12_pkt), .link_e_valid_o(t12_valid), .link_e_ready_i(t12_ready),
    .link_n_data_i('0), .link_n_valid_i(1'b0), .link_n_ready_o(),
    .link_n_data_o(), .link_n_valid_o(), .link_n_ready_i(1'b0),
    .link_s_data_i('0), .link_s_valid_i(1'b0), .link_s_ready_o(),
    .link_s_data_o(), .link_s_valid_o(), .link_s_ready_i(1'b0)
  );

  mem_tile #(.stub_p(STUB_NSE)) u_tile2 (
    .clk_i, .reset_i,
    .my_x_i(TILE2_X), .my_y_i(ROW_Y),
    .link_w_data_i(t12_pkt), .link_w_valid_i(t12_valid), .link_w_ready_o(t12_ready),
    .link_w_data_o(t21_pkt), .link_w_valid_o(t21_valid), .link_w_ready_i(t21_ready),
    .link_e_data_i('0), .link_e_valid_i(1'b0), .link_e_ready_o(),
    .link_e_data_o(), .link_e_valid_o(), .link_e_ready_i(1'b0),
    .link_n_data_i('0), .link_n_valid_i(1'b0), .link_n_ready_o(),
    .link_n_data_o(), .link_n_valid_o(), .link_n_ready_i(1'b0),
    .link_s_data_i('0), .link_s_valid_i(1'b0), .link_s_ready_o(),
    .link_s_data_o(), .link_s_valid_o(), .link_s_ready_i(1'b0)
  );

endmodule

`default_nettype wire

/* tb_mesh_pair.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_consts.svh"

module tb_mesh_pair;

  localparam int          CLK_HALF       = 10;   // 20 ns period
  localparam int          RESET_CYCLES   = 8;
  localparam int          FIXED_REQS     = 5;
  localparam int          RANDOM_REQS    = 60;
  localparam int          STALL_REQS     = 40;
  localparam int          TOTAL_REQS     = FIXED_REQS + RANDOM_REQS + STALL_REQS;
  localparam int          CYCLES_PER_REQ = 200;
  localparam int          WORDS          = 1 << `NOC_ADDR_W;
  localparam logic [31:0] SEED           = 32'h0366_1dbf;

  logic             clk_i;
  logic             reset_i;
  logic             host_req_i;
  noc_pkg::packet_t host_pkt_i;
  logic             host_ack_o;
  logic             resp_req_o;
  noc_pkg::packet_t resp_pkt_o;
  logic             resp_ack_i;

  logic [`NOC_DATA_W-1:0] ref_mem   [2][WORDS];   // Index 0 is tile 1
  logic                   ref_known [2][WORDS];   // Word written at least once
  noc_pkg::packet_t       exp1_q [$];
  noc_pkg::packet_t       exp2_q [$];
  logic                   known1_q [$];
  logic                   known2_q [$];
  int                     data_errors;
  int                     proto_errors;
  int                     sent_count;
  int                     recv_count;
  logic                   stall_en;                // Host slow to ack responses

  mesh_pair_top u_mesh_pair_top (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .host_req_i(host_req_i),
    .host_pkt_i(host_pkt_i),
    .host_ack_o(host_ack_o),
    .resp_req_o(resp_req_o),
    .resp_pkt_o(resp_pkt_o),
    .resp_ack_i(resp_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // Four-phase rules on the host side of the bridge
  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
      (!host_req_i && !host_ack_o) |=> !host_ack_o)
    else begin
      $display("%0t: host_ack_o rose while host_req_i was low", $time);
      proto_errors++;
    end

  resp_pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (resp_req_o && !resp_ack_i) |=> $stable(resp_pkt_o))
    else begin
      $display("%0t: resp_pkt_o changed while waiting for resp_ack_i", $time);
      proto_errors++;
    end

  resp_req_after_ack_low: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(resp_req_o) |-> !$past(resp_ack_i))
    else begin
      $display("%0t: resp_req_o rose again before resp_ack_i had fallen", $time);
      proto_errors++;
    end

  task automatic check_field(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    assert (got == want) else begin
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, want, got);
      data_errors++;
    end
  endtask

  // Predicts the response and runs the request handshake
  task automatic send_request(input noc_pkg::op_e op, input logic [`NOC_X_W-1:0] tile_x,
                              input logic [`NOC_ADDR_W-1:0] addr,
                              input logic [`NOC_DATA_W-1:0] data);
    noc_pkg::packet_t pkt;
    noc_pkg::packet_t want;
    logic             known;
    int               t;
    t          = int'(tile_x) - 1;
    pkt        = '0;
    pkt.op     = op;
    pkt.dst_x  = tile_x;
    pkt.addr   = addr;
    pkt.data   = data;             // Source is the host at column 0
    want       = '0;
    want.src_x = tile_x;
    want.addr  = addr;
    if (op == noc_pkg::OP_WRITE) begin
      want.op            = noc_pkg::OP_WACK;
      want.data          = data;   // Echo of the written word
      known              = 1'b1;
      ref_mem[t][addr]   = data;
      ref_known[t][addr] = 1'b1;
    end else begin
      want.op   = noc_pkg::OP_RDATA;
      want.data = ref_mem[t][addr];
      known     = ref_known[t][addr];
    end
    if (t == 0) begin
      exp1_q.push_back(want);
      known1_q.push_back(known);
    end else begin
      exp2_q.push_back(want);
      known2_q.push_back(known);
    end
    sent_count++;
    @(negedge clk_i);
    host_pkt_i = pkt;
    host_req_i = 1'b1;
    @(negedge clk_i);
    while (!host_ack_o) @(negedge clk_i);
    host_req_i = 1'b0;
    @(negedge clk_i);
    while (host_ack_o) @(negedge clk_i);
  endtask

  task automatic send_random_request();
    noc_pkg::op_e op;
    op = ($urandom_range(0, 1) == 0) ? noc_pkg::OP_WRITE : noc_pkg::OP_READ;
    send_request(op, 2'($urandom_range(1, 2)), 4'($urandom_range(0, WORDS - 1)),
                 16'($urandom));
  endtask

  task automatic check_response(input noc_pkg::packet_t got);
    noc_pkg::packet_t want;
    logic             known;
    recv_count++;
    if (got.src_x == 2'd1 && exp1_q.size() > 0) begin
      want  = exp1_q.pop_front();
      known = known1_q.pop_front();
    end else if (got.src_x == 2'd2 && exp2_q.size() > 0) begin
      want  = exp2_q.pop_front();
      known = known2_q.pop_front();
    end else begin
      $display("%0t: response from x=%0d arrived with no request outstanding",
               $time, int'(got.src_x));
      data_errors++;
      return;
    end
    check_field("resp_pkt_o.op", 32'(want.op), 32'(got.op));
    check_field("resp_pkt_o.dst_x", 32'(want.dst_x), 32'(got.dst_x));
    check_field("resp_pkt_o.dst_y", 32'(want.dst_y), 32'(got.dst_y));
    check_field("resp_pkt_o.src_y", 32'(want.src_y), 32'(got.src_y));
    check_field("resp_pkt_o.addr", 32'(want.addr), 32'(got.addr));
    if (known) check_field("resp_pkt_o.data", 32'(want.data), 32'(got.data));
  endtask

  task automatic wait_drain();
    wait (recv_count == sent_count);
    repeat (4) @(negedge clk_i);
  endtask

  // Host side of the response handshake
  initial begin : response_host
    resp_ack_i = 1'b0;
    wait (!reset_i);
    forever begin
      @(negedge clk_i);
      while (!resp_req_o) @(negedge clk_i);
      if (stall_en) repeat ($urandom_range(0, 12)) @(negedge clk_i);
      check_response(resp_pkt_o);
      resp_ack_i = 1'b1;
      @(negedge clk_i);
      while (resp_req_o) @(negedge clk_i);
      if (stall_en) repeat ($urandom_range(0, 4)) @(negedge clk_i);  // Late ack release
      resp_ack_i = 1'b0;
    end
  end

  initial begin : main_seq
    void'($urandom(SEED));
    reset_i      = 1'b1;
    host_req_i   = 1'b0;
    host_pkt_i   = '0;
    stall_en     = 1'b0;
    data_errors  = 0;
    proto_errors = 0;
    sent_count   = 0;
    recv_count   = 0;
    for (int t = 0; t < 2; t++) begin
      for (int a = 0; a < WORDS; a++) begin
        ref_mem[t][a]   = '0;
        ref_known[t][a] = 1'b0;
      end
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;

    repeat (6) begin   // Idle outputs before any request
      @(negedge clk_i);
      check_field("host_ack_o", 32'd0, 32'(host_ack_o));
      check_field("resp_req_o", 32'd0, 32'(resp_req_o));
    end

    send_request(noc_pkg::OP_WRITE, 2'd1, 4'h5, 16'hA5C3);
    send_request(noc_pkg::OP_READ, 2'd1, 4'h5, 16'h0000);
    wait_drain();

    // Tile 2 is reached through tile 1's router
    send_request(noc_pkg::OP_WRITE, 2'd2, 4'h5, 16'h3C5A);
    send_request(noc_pkg::OP_READ, 2'd2, 4'h5, 16'h0000);
    send_request(noc_pkg::OP_READ, 2'd1, 4'h5, 16'h0000);
    wait_drain();

    for (int n = 0; n < RANDOM_REQS; n++) send_random_request();
    wait_drain();

    stall_en = 1'b1;
    for (int n = 0; n < STALL_REQS; n++) send_random_request();
    wait_drain();
    repeat (10) @(negedge clk_i);

    assert (exp1_q.size() == 0 && exp2_q.size() == 0) else begin
      $display("%0t: expected responses were never delivered", $time);
      data_errors++;
    end
    $display("Errors: data %0d, protocol %0d, requests %0d, responses %0d",
             data_errors, proto_errors, sent_count, recv_count);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + CYCLES_PER_REQ * TOTAL_REQS) @(posedge clk_i);
    $display("Watchdog expired with %0d of %0d responses received", recv_count, sent_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
noc_pkg.sv
link_fifo.sv
rr_arbiter.sv
mesh_router.sv
mem_endpoint.sv
mem_tile.sv
host_link_bridge.sv
mesh_pair_top.sv
tb_mesh_pair.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mesh pair testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mesh_pair \
  -f src.f \
  -o tb_mesh_pair

./obj_dir/tb_mesh_pair | tee sim.log

# Decide the result from the log
grep -q "=== PASS ===" sim.log
echo "Simulation passed"
